/* compile.f */
logic/burst_pkg.sv
logic/burst_cmd_if.sv
logic/burst_cmd_queue.sv
logic/burst_simple_splitter.sv
logic/burst_natural_splitter.sv
logic/burst_gearbox.sv
logic/burst_split_top.sv
test/burst_split_tb.sv

/* logic/burst_cmd_if.sv */
/*
 * Burst command link
 * Valid/ready channel carrying a beat address, an origin 0 burst count
 * and the alignment mode of the command
 */
`timescale 1ns/1ps

interface burst_cmd_if
  #(
    parameter int ADDR_WIDTH  = burst_pkg::ADDR_WIDTH_DEFAULT,
    parameter int BURST_WIDTH = burst_pkg::MASTER_BURST_WIDTH_DEFAULT
    );

    logic                    valid;
    logic                    ready;
    logic [ADDR_WIDTH-1:0]   addr;
    // Origin 0 count, where 0 means a single beat
    logic [BURST_WIDTH-1:0]  burstcount;
    burst_pkg::t_align_mode  mode;

    // The source holds valid and the payload steady until ready is seen
    modport source (output valid, output addr, output burstcount, output mode, input ready);

    modport sink (input valid, input addr, input burstcount, input mode, output ready);

endinterface

/* logic/burst_cmd_queue.sv */
/*
 * Command queue
 * Small circular buffer with valid/ready on both sides, used for master
 * commands in front of the gearbox and for slave pieces behind it
 */
`timescale 1ns/1ps

module burst_cmd_queue
  #(
    parameter type t_payload   = logic,
    parameter int  QUEUE_DEPTH = burst_pkg::QUEUE_DEPTH_DEFAULT
    )
   (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  t_payload in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output t_payload out_data
    );

    localparam int PTR_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PTR_WIDTH-1:0] t_ptr;
    typedef logic [CNT_WIDTH-1:0] t_cnt;

    t_payload mem [QUEUE_DEPTH];
    t_ptr     wr_ptr;
    t_ptr     rd_ptr;
    t_cnt     count;
    logic     wr_en;
    logic     rd_en;

    // Pointers wrap explicitly so the depth need not be a power of two
    function automatic t_ptr next_ptr(t_ptr ptr);
        return (ptr == t_ptr'(QUEUE_DEPTH - 1)) ? t_ptr'(0) : ptr + t_ptr'(1);
    endfunction

    // A full queue still takes a word when the head leaves in the same cycle
    assign in_ready  = (count != t_cnt'(QUEUE_DEPTH)) || out_ready;
    assign out_valid = (count != t_cnt'(0));
    assign out_data  = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Occupancy moves only when exactly one side transfers
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= t_ptr'(0);
            rd_ptr <= t_ptr'(0);
            count  <= t_cnt'(0);
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (wr_en && !rd_en)
            begin
                count <= count + t_cnt'(1);
            end
            else if (rd_en && !wr_en)
            begin
                count <= count - t_cnt'(1);
            end
        end
    end

endmodule

/* logic/burst_gearbox.sv */
/*
 * Burst gearbox
 * Takes one master command at a time, runs it through both splitters and
 * forwards the pieces of the splitter named by the command's mode
 */
`timescale 1ns/1ps

module burst_gearbox
  #(
    parameter int ADDR_WIDTH         = burst_pkg::ADDR_WIDTH_DEFAULT,
    parameter int MASTER_BURST_WIDTH = burst_pkg::MASTER_BURST_WIDTH_DEFAULT,
    parameter int SLAVE_BURST_WIDTH  = burst_pkg::SLAVE_BURST_WIDTH_DEFAULT
    )
   (
    input  logic         clk,
    input  logic         reset_n,
    burst_cmd_if.sink    m_link,
    burst_cmd_if.source  s_link
    );

    typedef logic [ADDR_WIDTH-1:0]        t_addr;
    typedef logic [MASTER_BURST_WIDTH:0]  t_mcount1;
    typedef logic [SLAVE_BURST_WIDTH:0]   t_scount1;
    typedef logic [SLAVE_BURST_WIDTH-1:0] t_scount0;

    // High from the accepted command until its last piece transfers
    logic                   busy;
    burst_pkg::t_align_mode cur_mode;

    logic     m_xfer;
    logic     s_xfer;
    t_mcount1 m_count1;

    logic     simple_last;
    t_addr    simple_addr;
    t_scount1 simple_count1;
    logic     natural_last;
    t_addr    natural_addr;
    t_scount1 natural_count1;

    logic     sel_last;
    t_addr    sel_addr;
    t_scount1 sel_count1;

    // The splitters work in origin 1, so a zero count becomes one beat
    assign m_count1 = t_mcount1'(m_link.burstcount) + t_mcount1'(1);

    // A new command can enter in the cycle that the last piece leaves
    assign m_link.ready = !busy || (sel_last && s_link.ready);
    assign m_xfer       = m_link.valid && m_link.ready;
    assign s_xfer       = s_link.valid && s_link.ready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            busy     <= 1'b0;
            cur_mode <= burst_pkg::ALIGN_SIMPLE;
        end
        else if (m_xfer)
        begin
            busy     <= 1'b1;
            cur_mode <= m_link.mode;
        end
        else if (s_xfer && sel_last)
        begin
            busy <= 1'b0;
        end
    end

    // Both splitters track every command and the mode picks one of them
    burst_simple_splitter
      #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .MASTER_BURST_WIDTH(MASTER_BURST_WIDTH),
        .SLAVE_BURST_WIDTH(SLAVE_BURST_WIDTH)
        )
      simple_split
       (
        .clk,
        .reset_n,
        .new_req(m_xfer),
        .accept_req(s_xfer),
        .req_addr(m_link.addr),
        .req_burstcount(m_count1),
        .last_piece(simple_last),
        .piece_addr(simple_addr),
        .piece_burstcount(simple_count1)
        );

    burst_natural_splitter
      #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .MASTER_BURST_WIDTH(MASTER_BURST_WIDTH),
        .SLAVE_BURST_WIDTH(SLAVE_BURST_WIDTH)
        )
      natural_split
       (
        .clk,
        .reset_n,
        .new_req(m_xfer),
        .accept_req(s_xfer),
        .req_addr(m_link.addr),
        .req_burstcount(m_count1),
        .last_piece(natural_last),
        .piece_addr(natural_addr),
        .piece_burstcount(natural_count1)
        );

    assign sel_last   = (cur_mode == burst_pkg::ALIGN_NATURAL) ? natural_last : simple_last;
    assign sel_addr   = (cur_mode == burst_pkg::ALIGN_NATURAL) ? natural_addr : simple_addr;
    assign sel_count1 = (cur_mode == burst_pkg::ALIGN_NATURAL) ? natural_count1 : simple_count1;

    // Pieces leave in origin 0 again
    assign s_link.valid      = busy;
    assign s_link.addr       = sel_addr;
    assign s_link.burstcount = t_scount0'(sel_count1 - t_scount1'(1));
    assign s_link.mode       = cur_mode;

endmodule

/* logic/burst_natural_splitter.sv */
/*
 * Natural burst splitter
 * Cuts a master burst into power of two pieces, each aligned to its own
 * size and no larger than the slave maximum. Counts are origin 1
 */
`timescale 1ns/1ps

module burst_natural_splitter
  #(
    parameter int ADDR_WIDTH         = burst_pkg::ADDR_WIDTH_DEFAULT,
    parameter int MASTER_BURST_WIDTH = burst_pkg::MASTER_BURST_WIDTH_DEFAULT,
    parameter int SLAVE_BURST_WIDTH  = burst_pkg::SLAVE_BURST_WIDTH_DEFAULT
    )
   (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        new_req,
    input  logic                        accept_req,
    input  logic [ADDR_WIDTH-1:0]       req_addr,
    input  logic [MASTER_BURST_WIDTH:0] req_burstcount,
    output logic                        last_piece,
    output logic [ADDR_WIDTH-1:0]       piece_addr,
    output logic [SLAVE_BURST_WIDTH:0]  piece_burstcount
    );

    typedef logic [ADDR_WIDTH-1:0]       t_addr;
    typedef logic [MASTER_BURST_WIDTH:0] t_mcount;
    typedef logic [SLAVE_BURST_WIDTH:0]  t_scount;

    localparam int SLAVE_MAX = 1 << SLAVE_BURST_WIDTH;

    t_mcount remaining;
    // Remaining count with only its highest set bit kept
    t_mcount remaining_top;
    t_mcount next_remaining;
    t_addr   next_addr;

    // Keep the most significant one, scanning upward so the last hit wins
    function automatic t_mcount highest_one(t_mcount count);
        t_mcount result;
        result = t_mcount'(0);
        for (int i = 0; i <= MASTER_BURST_WIDTH; i++)
        begin
            if (count[i])
            begin
                result = t_mcount'(1) << i;
            end
        end
        return result;
    endfunction

    // The lowest set bit among the size limit and the address gives the
    // smallest of the two, and a clean run of low bits allows a full piece
    function automatic t_scount aligned_size(t_mcount top, t_addr addr);
        for (int i = 0; i < SLAVE_BURST_WIDTH; i++)
        begin
            if (top[i] || addr[i])
            begin
                return t_scount'(1 << i);
            end
        end
        return t_scount'(SLAVE_MAX);
    endfunction

    // True when one aligned power of two piece covers the whole count
    function automatic logic fits_one_piece(t_mcount count, t_addr addr);
        logic fits_max;
        logic single_bit;
        logic aligned;
        fits_max   = (count <= t_mcount'(SLAVE_MAX));
        single_bit = ~|(count & (count - t_mcount'(1)));
        aligned    = ~|(addr & t_addr'(count - t_mcount'(1)));
        return fits_max && single_bit && aligned;
    endfunction

    assign piece_burstcount = aligned_size(remaining_top, piece_addr);
    assign next_remaining   = remaining - t_mcount'(piece_burstcount);
    assign next_addr        = piece_addr + t_addr'(piece_burstcount);

    always_ff @(posedge clk)
    begin
        if (new_req)
        begin
            remaining     <= req_burstcount;
            remaining_top <= highest_one(req_burstcount);
            piece_addr    <= req_addr;
            last_piece    <= fits_one_piece(req_burstcount, req_addr);
        end
        else if (accept_req)
        begin
            // Step past the piece just taken and size up the one after it
            remaining     <= next_remaining;
            remaining_top <= highest_one(next_remaining);
            piece_addr    <= next_addr;
            last_piece    <= fits_one_piece(next_remaining, next_addr);
        end

        if (!reset_n)
        begin
            remaining     <= t_mcount'(0);
            remaining_top <= t_mcount'(0);
            last_piece    <= 1'b1;
        end
    end

endmodule

/* logic/burst_pkg.sv */
/*
 * Burst splitter shared definitions
 * Default widths and depths for the command path and the per-command
 * alignment mode that picks which splitter shapes the slave pieces
 */
package burst_pkg;

    // Beat address width used when the top level is built with defaults
    localparam int ADDR_WIDTH_DEFAULT = 16;

    // Master burst counts are origin 0, so 6 bits cover up to 64 beats
    localparam int MASTER_BURST_WIDTH_DEFAULT = 6;

    // Slave burst counts are origin 0, so 3 bits cover up to 8 beats
    localparam int SLAVE_BURST_WIDTH_DEFAULT = 3;

    // Entries in each of the master and slave command queues
    localparam int QUEUE_DEPTH_DEFAULT = 4;

    // Alignment mode carried with every command
    // Simple pieces are the slave maximum until the remainder fits
    // Natural pieces are powers of two aligned to their own size
    typedef enum logic
    {
        ALIGN_SIMPLE  = 1'b0,
        ALIGN_NATURAL = 1'b1
    } t_align_mode;

endpackage

/* logic/burst_simple_splitter.sv */
/*
 * Simple burst splitter
 * Cuts a master burst into slave maximum pieces with the remainder last
 * Counts on both ports are origin 1
 */
`timescale 1ns/1ps

module burst_simple_splitter
  #(
    parameter int ADDR_WIDTH         = burst_pkg::ADDR_WIDTH_DEFAULT,
    parameter int MASTER_BURST_WIDTH = burst_pkg::MASTER_BURST_WIDTH_DEFAULT,
    parameter int SLAVE_BURST_WIDTH  = burst_pkg::SLAVE_BURST_WIDTH_DEFAULT
    )
   (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        new_req,
    input  logic                        accept_req,
    input  logic [ADDR_WIDTH-1:0]       req_addr,
    input  logic [MASTER_BURST_WIDTH:0] req_burstcount,
    output logic                        last_piece,
    output logic [ADDR_WIDTH-1:0]       piece_addr,
    output logic [SLAVE_BURST_WIDTH:0]  piece_burstcount
    );

    typedef logic [ADDR_WIDTH-1:0]       t_addr;
    typedef logic [MASTER_BURST_WIDTH:0] t_mcount;
    typedef logic [SLAVE_BURST_WIDTH:0]  t_scount;

    // Largest slave burst expressed as an origin 1 count
    localparam int SLAVE_MAX = 1 << SLAVE_BURST_WIDTH;

    // Beats of the current command not yet handed to the slave
    t_mcount remaining;

    always_ff @(posedge clk)
    begin
        if (new_req)
        begin
            remaining  <= req_burstcount;
            piece_addr <= req_addr;
            last_piece <= (req_burstcount <= t_mcount'(SLAVE_MAX));
        end
        else if (accept_req)
        begin
            // Every piece before the last is full size, and the count left
            // after the last piece is never looked at
            remaining  <= remaining - t_mcount'(SLAVE_MAX);
            piece_addr <= piece_addr + t_addr'(SLAVE_MAX);
            last_piece <= (remaining <= t_mcount'(2 * SLAVE_MAX));
        end

        if (!reset_n)
        begin
            remaining  <= t_mcount'(0);
            last_piece <= 1'b1;
        end
    end

    // The last piece carries whatever is left, all others the maximum
    assign piece_burstcount = last_piece ? t_scount'(remaining) : t_scount'(SLAVE_MAX);

endmodule

/* logic/burst_split_top.sv */
/*
 * Burst split subsystem
 * Master commands pass through an input queue, the gearbox and an output
 * queue that presents slave sized pieces
 */
`timescale 1ns/1ps

module burst_split_top
  #(
    parameter int ADDR_WIDTH         = burst_pkg::ADDR_WIDTH_DEFAULT,
    parameter int MASTER_BURST_WIDTH = burst_pkg::MASTER_BURST_WIDTH_DEFAULT,
    parameter int SLAVE_BURST_WIDTH  = burst_pkg::SLAVE_BURST_WIDTH_DEFAULT,
    parameter int QUEUE_DEPTH        = burst_pkg::QUEUE_DEPTH_DEFAULT
    )
   (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          m_valid,
    output logic                          m_ready,
    input  logic [ADDR_WIDTH-1:0]         m_addr,
    input  logic [MASTER_BURST_WIDTH-1:0] m_burstcount,
    input  burst_pkg::t_align_mode        m_mode,
    output logic                          s_valid,
    input  logic                          s_ready,
    output logic [ADDR_WIDTH-1:0]         s_addr,
    output logic [SLAVE_BURST_WIDTH-1:0]  s_burstcount
    );

    // Queue payloads for the two sides, both with origin 0 counts
    typedef struct packed
    {
        logic [ADDR_WIDTH-1:0]         addr;
        logic [MASTER_BURST_WIDTH-1:0] burstcount;
        burst_pkg::t_align_mode        mode;
    } t_m_cmd;

    typedef struct packed
    {
        logic [ADDR_WIDTH-1:0]        addr;
        logic [SLAVE_BURST_WIDTH-1:0] burstcount;
    } t_s_cmd;

    t_m_cmd m_in_cmd;
    t_m_cmd m_out_cmd;
    t_s_cmd s_in_cmd;
    t_s_cmd s_out_cmd;

    burst_cmd_if #(.ADDR_WIDTH(ADDR_WIDTH), .BURST_WIDTH(MASTER_BURST_WIDTH)) m_link();
    burst_cmd_if #(.ADDR_WIDTH(ADDR_WIDTH), .BURST_WIDTH(SLAVE_BURST_WIDTH)) s_link();

    assign m_in_cmd = '{addr: m_addr, burstcount: m_burstcount, mode: m_mode};

    burst_cmd_queue #(.t_payload(t_m_cmd), .QUEUE_DEPTH(QUEUE_DEPTH)) m_queue
       (
        .clk,
        .reset_n,
        .in_valid(m_valid),
        .in_ready(m_ready),
        .in_data(m_in_cmd),
        .out_valid(m_link.valid),
        .out_ready(m_link.ready),
        .out_data(m_out_cmd)
        );

    assign m_link.addr       = m_out_cmd.addr;
    assign m_link.burstcount = m_out_cmd.burstcount;
    assign m_link.mode       = m_out_cmd.mode;

    burst_gearbox
      #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .MASTER_BURST_WIDTH(MASTER_BURST_WIDTH),
        .SLAVE_BURST_WIDTH(SLAVE_BURST_WIDTH)
        )
      gearbox
       (
        .clk,
        .reset_n,
        .m_link(m_link.sink),
        .s_link(s_link.source)
        );

    // The slave port has no mode, so only address and count are queued
    assign s_in_cmd = '{addr: s_link.addr, burstcount: s_link.burstcount};

    burst_cmd_queue #(.t_payload(t_s_cmd), .QUEUE_DEPTH(QUEUE_DEPTH)) s_queue
       (
        .clk,
        .reset_n,
        .in_valid(s_link.valid),
        .in_ready(s_link.ready),
        .in_data(s_in_cmd),
        .out_valid(s_valid),
        .out_ready(s_ready),
        .out_data(s_out_cmd)
        );

    assign s_addr       = s_out_cmd.addr;
    assign s_burstcount = s_out_cmd.burstcount;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the burst splitter testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module burst_split_tb -o burst_split_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/burst_split_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "All tests passed!"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* test/burst_split_tb.sv */
/*
 * Burst split testbench
 * Feeds a table of master commands into the splitter under random slave
 * back-pressure and checks every slave piece against the table
 */
`timescale 1ns/1ps

module burst_split_tb;

    localparam int ADDR_WIDTH         = burst_pkg::ADDR_WIDTH_DEFAULT;
    localparam int MASTER_BURST_WIDTH = burst_pkg::MASTER_BURST_WIDTH_DEFAULT;
    localparam int SLAVE_BURST_WIDTH  = burst_pkg::SLAVE_BURST_WIDTH_DEFAULT;

    typedef logic [ADDR_WIDTH-1:0]         t_addr;
    typedef logic [MASTER_BURST_WIDTH-1:0] t_mcount;
    typedef logic [SLAVE_BURST_WIDTH-1:0]  t_scount;
    // Beats of a whole command, origin 1, so one bit wider than the port
    typedef logic [MASTER_BURST_WIDTH:0]   t_beats;

    localparam int NUM_ROWS   = 10;
    localparam int MAX_PIECES = 8;

    // Master commands, with beat counts in origin 1
    localparam int ROW_ADDR [NUM_ROWS] =
        '{'h0003, 'h0005, 'h0010, 'h1234, 'h0000, 'h0007, 'h0002, 'h00F0, 'h0101, 'h0018};
    localparam int ROW_BEATS [NUM_ROWS] = '{21, 13, 4, 7, 64, 10, 6, 1, 17, 24};
    localparam burst_pkg::t_align_mode ROW_MODE [NUM_ROWS] = '{
        burst_pkg::ALIGN_SIMPLE, burst_pkg::ALIGN_NATURAL, burst_pkg::ALIGN_NATURAL,
        burst_pkg::ALIGN_SIMPLE, burst_pkg::ALIGN_SIMPLE, burst_pkg::ALIGN_NATURAL,
        burst_pkg::ALIGN_NATURAL, burst_pkg::ALIGN_SIMPLE, burst_pkg::ALIGN_SIMPLE,
        burst_pkg::ALIGN_NATURAL
    };
    localparam int ROW_NPIECES [NUM_ROWS] = '{3, 4, 1, 1, 8, 3, 2, 1, 3, 3};

    // Expected slave pieces of each command, unused slots left at zero
    localparam int EXP_ADDR [NUM_ROWS][MAX_PIECES] = '{
        '{'h03, 'h0B, 'h13, 0, 0, 0, 0, 0},
        '{'h05, 'h06, 'h08, 'h10, 0, 0, 0, 0},
        '{'h10, 0, 0, 0, 0, 0, 0, 0},
        '{'h1234, 0, 0, 0, 0, 0, 0, 0},
        '{'h00, 'h08, 'h10, 'h18, 'h20, 'h28, 'h30, 'h38},
        '{'h07, 'h08, 'h10, 0, 0, 0, 0, 0},
        '{'h02, 'h04, 0, 0, 0, 0, 0, 0},
        '{'hF0, 0, 0, 0, 0, 0, 0, 0},
        '{'h101, 'h109, 'h111, 0, 0, 0, 0, 0},
        '{'h18, 'h20, 'h28, 0, 0, 0, 0, 0}
    };
    localparam int EXP_BEATS [NUM_ROWS][MAX_PIECES] = '{
        '{8, 8, 5, 0, 0, 0, 0, 0},
        '{1, 2, 8, 2, 0, 0, 0, 0},
        '{4, 0, 0, 0, 0, 0, 0, 0},
        '{7, 0, 0, 0, 0, 0, 0, 0},
        '{8, 8, 8, 8, 8, 8, 8, 8},
        '{1, 8, 1, 0, 0, 0, 0, 0},
        '{2, 4, 0, 0, 0, 0, 0, 0},
        '{1, 0, 0, 0, 0, 0, 0, 0},
        '{8, 8, 1, 0, 0, 0, 0, 0},
        '{8, 8, 8, 0, 0, 0, 0, 0}
    };

    function automatic int total_pieces();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            sum = sum + ROW_NPIECES[i];
        end
        return sum;
    endfunction

    localparam int TOTAL_PIECES   = total_pieces();
    localparam int TIMEOUT_CYCLES = 8 * TOTAL_PIECES + 100;

    logic                   clk = 1'b0;
    logic                   reset_n;
    logic                   m_valid;
    logic                   m_ready;
    t_addr                  m_addr;
    t_mcount                m_burstcount;
    burst_pkg::t_align_mode m_mode;
    logic                   s_valid;
    logic                   s_ready;
    t_addr                  s_addr;
    t_scount                s_burstcount;

    logic [31:0] lfsr = 32'h1e1b;
    int          cycle_count = 0;
    int          mon_row = 0;
    int          mon_piece = 0;
    int          pieces_seen = 0;
    t_beats      beat_sum = '0;
    t_beats      piece_beats;
    t_addr       prev_addr;
    t_beats      prev_beats;

    burst_split_top dut0
       (
        .clk,
        .reset_n,
        .m_valid,
        .m_ready,
        .m_addr,
        .m_burstcount,
        .m_mode,
        .s_valid,
        .s_ready,
        .s_addr,
        .s_burstcount
        );

    always #20 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic check_flag(input logic expected, input logic actual, input string what);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, what, expected, actual);
            $display("Test failures found");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_addr(input t_addr expected, input t_addr actual, input string what);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s expected 0x%h, got 0x%h",
                     $time, what, expected, actual);
            $display("Test failures found");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_burstcount(input t_scount expected, input t_scount actual,
                                    input string what);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d",
                     $time, what, expected, actual);
            $display("Test failures found");
            $fatal(1, "burst count mismatch");
        end
    endtask

    task automatic check_beat_total(input t_beats expected, input t_beats actual,
                                    input string what);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d",
                     $time, what, expected, actual);
            $display("Test failures found");
            $fatal(1, "beat total mismatch");
        end
    endtask

    // One fresh bit per cycle decides whether the slave takes a piece
    always @(posedge clk)
    begin
        if (reset_n)
        begin
            lfsr = lfsr_step(lfsr);
            s_ready <= lfsr[0];
        end
    end

    always @(posedge clk)
    begin
        if (reset_n)
        begin
            cycle_count = cycle_count + 1;
        end
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the slave pieces did not all arrive within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    // Sampled on the falling edge, where valid and ready show what the
    // next rising edge transfers
    always @(negedge clk)
    begin
        if (reset_n && s_valid && s_ready)
        begin
            if (mon_row >= NUM_ROWS)
            begin
                $display("An extra slave piece arrived after all expected pieces at %0t", $time);
                $display("Test failures found");
                $fatal(1, "extra slave piece");
            end
            else
            begin
                piece_beats = t_beats'(s_burstcount) + t_beats'(1);
                check_addr(t_addr'(EXP_ADDR[mon_row][mon_piece]), s_addr, "piece address");
                check_burstcount(t_scount'(EXP_BEATS[mon_row][mon_piece] - 1), s_burstcount,
                                 "piece burst count");
                // Pieces must tile the command with no gap or overlap
                if (mon_piece == 0)
                begin
                    check_addr(t_addr'(ROW_ADDR[mon_row]), s_addr, "first piece address");
                end
                else
                begin
                    check_addr(prev_addr + t_addr'(prev_beats), s_addr, "piece continuity");
                end
                beat_sum    = beat_sum + piece_beats;
                prev_addr   = s_addr;
                prev_beats  = piece_beats;
                pieces_seen = pieces_seen + 1;
                if (mon_piece == ROW_NPIECES[mon_row] - 1)
                begin
                    check_beat_total(t_beats'(ROW_BEATS[mon_row]), beat_sum, "command beats");
                    mon_row   = mon_row + 1;
                    mon_piece = 0;
                    beat_sum  = '0;
                end
                else
                begin
                    mon_piece = mon_piece + 1;
                end
            end
        end
    end

    initial
    begin
        reset_n      = 1'b0;
        m_valid      = 1'b0;
        m_addr       = '0;
        m_burstcount = '0;
        m_mode       = burst_pkg::ALIGN_SIMPLE;
        s_ready      = 1'b0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;

        // Idle state right after reset
        @(negedge clk);
        check_flag(1'b0, s_valid, "s_valid after reset");
        check_flag(1'b1, m_ready, "m_ready after reset");
        @(posedge clk);

        // Each command is held until the rising edge that accepts it
        for (int row = 0; row < NUM_ROWS; row++)
        begin
            m_valid      <= 1'b1;
            m_addr       <= t_addr'(ROW_ADDR[row]);
            m_burstcount <= t_mcount'(ROW_BEATS[row] - 1);
            m_mode       <= ROW_MODE[row];
            @(negedge clk);
            while (!m_ready)
            begin
                @(negedge clk);
            end
            @(posedge clk);
        end
        m_valid <= 1'b0;

        while (mon_row < NUM_ROWS)
        begin
            @(posedge clk);
        end
        // A quiet stretch catches any piece beyond the table, whether it
        // transfers or is left waiting at the slave port
        repeat (20) @(posedge clk);
        @(negedge clk);

        if (pieces_seen == TOTAL_PIECES && !s_valid)
        begin
            $display("All tests passed!");
            $finish;
        end
        else
        begin
            $display("Received %0d pieces where %0d were expected, and a piece is still pending",
                     pieces_seen, TOTAL_PIECES);
            $display("Test failures found");
            $fatal(1, "piece count mismatch");
        end
    end

endmodule
